// File: Makefile
SIM      = verilator
TOP      = tb_feeder_bank
FILELIST = feeder_bank.f
FLAGS    = --binary --timing -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: feeder_bank.f
hdl/feeder_pkg.sv
hdl/feeder_ram.sv
hdl/feeder_write_ctl.sv
hdl/feeder_read_ctl.sv
hdl/feeder_buffer_tracker.sv
hdl/feeder_slice.sv
hdl/feeder_bank.sv
tb/tb_feeder_bank.sv

// File: hdl/feeder_bank.sv
/*
 * Feeder bank top level
 * Write and read controllers, buffer tracker and a daisy chain
 * of feeder slices, one cycle apart
 */
`default_nettype none

module feeder_bank #(
   parameter int NUM_FEEDERS      = 2,
   parameter int LEAD_INTERLEAVE  = 4,
   parameter int REUSE_COUNT      = 2,
   // Must be even, two vectors per write word
   parameter int INTERLEAVE_DEPTH = 4
) (
   input  wire                                     clk,
   input  wire                                     rst,
   // Host write port
   input  wire                                     wr_valid,
   input  wire feeder_pkg::wr_word_t               wr_data,
   output logic                                    wr_ready,
   // Read request port, no back-pressure on the data side
   input  wire                                     rd_valid,
   output logic                                    rd_ready,
   output feeder_pkg::vec_t [NUM_FEEDERS-1:0]      rd_data,
   output logic [NUM_FEEDERS-1:0]                  rd_data_valid
);

   // ---------------------------------------------------------------------
   // Buffer geometry
   // ---------------------------------------------------------------------
   localparam int VECS_PER_BUF  = LEAD_INTERLEAVE * INTERLEAVE_DEPTH;
   localparam int WORDS_PER_BUF = VECS_PER_BUF / 2;
   // Two ping-pong buffers per feeder
   localparam int DEPTH_WORDS   = 2 * WORDS_PER_BUF;

   logic wr_accept;
   logic rd_accept;
   logic wr_done;
   logic rd_done;

   // Element 0 comes from the controllers, element i+1 from slice i
   feeder_pkg::wr_cmd_t wr_chain [NUM_FEEDERS+1];
   feeder_pkg::rd_cmd_t rd_chain [NUM_FEEDERS+1];

   assign wr_accept = wr_valid && wr_ready;
   assign rd_accept = rd_valid && rd_ready;

   // ---------------------------------------------------------------------
   // Control
   // ---------------------------------------------------------------------
   feeder_write_ctl #(
      .NUM_FEEDERS   (NUM_FEEDERS),
      .WORDS_PER_BUF (WORDS_PER_BUF)
   ) u_write_ctl (
      .clk       (clk),
      .rst       (rst),
      .wr_accept (wr_accept),
      .wr_data   (wr_data),
      .wr_cmd    (wr_chain[0]),
      .wr_done   (wr_done)
   );

   feeder_read_ctl #(
      .LEAD_INTERLEAVE  (LEAD_INTERLEAVE),
      .REUSE_COUNT      (REUSE_COUNT),
      .INTERLEAVE_DEPTH (INTERLEAVE_DEPTH)
   ) u_read_ctl (
      .clk       (clk),
      .rst       (rst),
      .rd_accept (rd_accept),
      .rd_cmd    (rd_chain[0]),
      .rd_done   (rd_done)
   );

   // Buffer counted full before the last word reaches later slices
   // Reads trail on the same chain, so they never overtake it
   feeder_buffer_tracker u_tracker (
      .clk      (clk),
      .rst      (rst),
      .wr_done  (wr_done),
      .rd_done  (rd_done),
      .wr_ready (wr_ready),
      .rd_ready (rd_ready)
   );

   // ---------------------------------------------------------------------
   // Feeder chain
   // ---------------------------------------------------------------------
   for (genvar i = 0; i < NUM_FEEDERS; i++) begin : g_slice
      feeder_slice #(
         .FEEDER_INDEX (i),
         .DEPTH_WORDS  (DEPTH_WORDS)
      ) u_slice (
         .clk           (clk),
         .rst           (rst),
         .wr_cmd_in     (wr_chain[i]),
         .rd_cmd_in     (rd_chain[i]),
         .wr_cmd_out    (wr_chain[i+1]),
         .rd_cmd_out    (rd_chain[i+1]),
         .rd_data       (rd_data[i]),
         .rd_data_valid (rd_data_valid[i])
      );
   end

endmodule

`default_nettype wire

// File: hdl/feeder_buffer_tracker.sv
/*
 * Buffer tracker
 * Counts filled ping-pong buffers and registers the write and
 * read ready flags from the count
 */
`default_nettype none

module feeder_buffer_tracker (
   input  wire  clk,
   input  wire  rst,
   input  wire  wr_done,
   input  wire  rd_done,
   output logic wr_ready,
   output logic rd_ready
);

   // Filled buffers, 0 to 2
   logic [1:0] fill_cnt;
   logic [1:0] fill_next;

   // ---------------------------------------------------------------------
   // Next count
   // ---------------------------------------------------------------------
   always_comb begin
      case ({wr_done, rd_done})
         2'b10:   fill_next = fill_cnt + 2'd1;
         2'b01:   fill_next = fill_cnt - 2'd1;
         // Fill and drain together, or nothing
         default: fill_next = fill_cnt;
      endcase
   end

   // Ready flags follow the new count one cycle after a pulse
   always_ff @(posedge clk) begin
      if (rst) begin
         fill_cnt <= 2'd0;
         wr_ready <= 1'b0;
         rd_ready <= 1'b0;
      end else begin
         fill_cnt <= fill_next;
         // Room while at least one buffer is free
         wr_ready <= (fill_next < 2'd2);
         // Data while at least one buffer is filled
         rd_ready <= (fill_next > 2'd0);
      end
   end

endmodule

`default_nettype wire

// File: hdl/feeder_pkg.sv
/*
 * Feeder bank shared definitions
 * Element and vector widths, memory address types and the command
 * structs that travel down the feeder chain
 */
`default_nettype none

package feeder_pkg;

   // ---------------------------------------------------------------------
   // Widths
   // ---------------------------------------------------------------------

   // Bits per matrix element
   localparam int DATA_WIDTH = 8;
   // Elements per operand vector
   localparam int VECTOR_LENGTH = 4;
   localparam int VECTOR_WIDTH = DATA_WIDTH * VECTOR_LENGTH;
   // Word address bits
   // Memory per feeder stays below 2**MAX_ADDR_WIDTH words
   localparam int MAX_ADDR_WIDTH = 8;
   // Enough for 32 feeders
   localparam int FEEDER_SEL_WIDTH = 5;

   // ---------------------------------------------------------------------
   // Types
   // ---------------------------------------------------------------------

   typedef logic [VECTOR_WIDTH-1:0] vec_t;
   // Low half holds the even vector address, high half the odd one
   typedef logic [2*VECTOR_WIDTH-1:0] wr_word_t;
   typedef logic [MAX_ADDR_WIDTH-1:0] word_addr_t;
   // One bit wider than a word address, LSB picks the half
   typedef logic [MAX_ADDR_WIDTH:0] vec_addr_t;
   typedef logic [FEEDER_SEL_WIDTH-1:0] feeder_sel_t;

   // Write command passed along the chain
   typedef struct packed {
      logic        valid;
      feeder_sel_t sel;
      word_addr_t  addr;
      wr_word_t    data;
   } wr_cmd_t;

   // Read command, same address for every feeder
   typedef struct packed {
      logic      valid;
      vec_addr_t addr;
   } rd_cmd_t;

   // Counter width for n states, never below one bit
   function automatic int cnt_width(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage

`default_nettype wire

// File: hdl/feeder_ram.sv
/*
 * Feeder memory
 * Simple dual port, two-vector write words, one-vector reads.
 * Two cycles from read address to read data.
 */
`default_nettype none

module feeder_ram #(
   parameter int DEPTH_WORDS = 16
) (
   input  wire                         clk,
   input  wire                         wr_en,
   input  wire feeder_pkg::word_addr_t wr_addr,
   input  wire feeder_pkg::wr_word_t   wr_data,
   input  wire                         rd_en,
   input  wire feeder_pkg::vec_addr_t  rd_addr,
   output feeder_pkg::vec_t            rd_data
);

   localparam int AW = feeder_pkg::cnt_width(DEPTH_WORDS);
   localparam int VW = feeder_pkg::VECTOR_WIDTH;

   feeder_pkg::wr_word_t  mem [DEPTH_WORDS];
   feeder_pkg::vec_addr_t rd_addr_q;
   feeder_pkg::wr_word_t  rd_word;

   // Write port, whole word at once
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr[AW-1:0]] <= wr_data;
      end
   end

   // Stage 1: capture the vector address
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_addr_q <= rd_addr;
      end
   end

   // Word address drops the half-select bit
   assign rd_word = mem[rd_addr_q[AW:1]];

   // Stage 2: pick the half, odd address takes the upper vector
   always_ff @(posedge clk) begin
      rd_data <= rd_addr_q[0] ? rd_word[VW +: VW] : rd_word[0 +: VW];
   end

endmodule

`default_nettype wire

// File: hdl/feeder_read_ctl.sv
/*
 * Feeder read controller
 * Walks a filled buffer as depth, reuse and column counters
 * and forms the common vector address for all feeders
 */
`default_nettype none

module feeder_read_ctl #(
   parameter int LEAD_INTERLEAVE  = 4,
   parameter int REUSE_COUNT      = 2,
   parameter int INTERLEAVE_DEPTH = 4
) (
   input  wire                 clk,
   input  wire                 rst,
   input  wire                 rd_accept,
   output feeder_pkg::rd_cmd_t rd_cmd,
   output logic                rd_done
);

   localparam int VECS_PER_BUF = LEAD_INTERLEAVE * INTERLEAVE_DEPTH;
   localparam int COL_W        = feeder_pkg::cnt_width(LEAD_INTERLEAVE);
   localparam int REUSE_W      = feeder_pkg::cnt_width(REUSE_COUNT);
   localparam int DEPTH_W      = feeder_pkg::cnt_width(INTERLEAVE_DEPTH);
   // Vector offset of buffer 1
   localparam feeder_pkg::vec_addr_t BUF_OFFSET = feeder_pkg::vec_addr_t'(VECS_PER_BUF);

   logic [COL_W-1:0]      col_cnt;
   logic [REUSE_W-1:0]    reuse_cnt;
   logic [DEPTH_W-1:0]    depth_cnt;
   logic                  rd_buf;
   logic                  last_col;
   logic                  last_reuse;
   logic                  last_depth;
   feeder_pkg::vec_addr_t row_base;

   // ---------------------------------------------------------------------
   // Wrap conditions
   // ---------------------------------------------------------------------
   assign last_col   = (col_cnt == COL_W'(LEAD_INTERLEAVE - 1));
   assign last_reuse = (reuse_cnt == REUSE_W'(REUSE_COUNT - 1));
   assign last_depth = (depth_cnt == DEPTH_W'(INTERLEAVE_DEPTH - 1));

   // Final step of a buffer pass
   assign rd_done = rd_accept && last_col && last_reuse && last_depth;

   // First vector of the current row, reuse does not move it
   assign row_base = (rd_buf ? BUF_OFFSET : '0) +
                     feeder_pkg::vec_addr_t'(depth_cnt * LEAD_INTERLEAVE);

   always_comb begin
      rd_cmd.valid = rd_accept;
      rd_cmd.addr  = row_base + feeder_pkg::vec_addr_t'(col_cnt);
   end

   // ---------------------------------------------------------------------
   // Counters
   // Column is innermost, then reuse, then depth, then buffer
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         col_cnt   <= '0;
         reuse_cnt <= '0;
         depth_cnt <= '0;
         rd_buf    <= 1'b0;
      end else if (rd_accept) begin
         if (last_col) begin
            col_cnt <= '0;
            if (last_reuse) begin
               reuse_cnt <= '0;
               if (last_depth) begin
                  depth_cnt <= '0;
                  rd_buf    <= ~rd_buf;
               end else begin
                  depth_cnt <= depth_cnt + 1'b1;
               end
            end else begin
               // Replay the same row
               reuse_cnt <= reuse_cnt + 1'b1;
            end
         end else begin
            col_cnt <= col_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/feeder_slice.sv
/*
 * Feeder slice
 * One stage of the chain. Registers the commands, writes its own
 * block, reads one vector per request and zeroes the idle output.
 */
`default_nettype none

module feeder_slice #(
   parameter int FEEDER_INDEX = 0,
   parameter int DEPTH_WORDS  = 16
) (
   input  wire                      clk,
   input  wire                      rst,
   input  wire feeder_pkg::wr_cmd_t wr_cmd_in,
   input  wire feeder_pkg::rd_cmd_t rd_cmd_in,
   output feeder_pkg::wr_cmd_t      wr_cmd_out,
   output feeder_pkg::rd_cmd_t      rd_cmd_out,
   output feeder_pkg::vec_t         rd_data,
   output logic                     rd_data_valid
);

   feeder_pkg::wr_cmd_t wr_cmd_q;
   feeder_pkg::rd_cmd_t rd_cmd_q;
   logic                mem_wr_en;
   logic                rd_valid_q;
   logic                rd_valid_qq;
   feeder_pkg::vec_t    mem_rd_data;

   // ---------------------------------------------------------------------
   // Command registers
   // ---------------------------------------------------------------------
   // Payload is free running, only the valid bits clear
   always_ff @(posedge clk) begin
      wr_cmd_q <= wr_cmd_in;
      rd_cmd_q <= rd_cmd_in;
      if (rst) begin
         wr_cmd_q.valid <= 1'b0;
         rd_cmd_q.valid <= 1'b0;
      end
   end

   // Next slice sees the commands one cycle later
   assign wr_cmd_out = wr_cmd_q;
   assign rd_cmd_out = rd_cmd_q;

   // Only the block addressed to this feeder lands here
   assign mem_wr_en = wr_cmd_q.valid &&
                      (wr_cmd_q.sel == feeder_pkg::feeder_sel_t'(FEEDER_INDEX));

   feeder_ram #(
      .DEPTH_WORDS (DEPTH_WORDS)
   ) u_ram (
      .clk     (clk),
      .wr_en   (mem_wr_en),
      .wr_addr (wr_cmd_q.addr),
      .wr_data (wr_cmd_q.data),
      .rd_en   (rd_cmd_q.valid),
      .rd_addr (rd_cmd_q.addr),
      .rd_data (mem_rd_data)
   );

   // ---------------------------------------------------------------------
   // Read valid follows the memory latency
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid_q    <= 1'b0;
         rd_valid_qq   <= 1'b0;
         rd_data_valid <= 1'b0;
      end else begin
         rd_valid_q    <= rd_cmd_q.valid;
         rd_valid_qq   <= rd_valid_q;
         rd_data_valid <= rd_valid_qq;
      end
   end

   // Output register, zero whenever no read is due
   always_ff @(posedge clk) begin
      rd_data <= rd_valid_qq ? mem_rd_data : '0;
   end

endmodule

`default_nettype wire

// File: hdl/feeder_write_ctl.sv
/*
 * Feeder write controller
 * Spreads host words over the feeders, one block per feeder,
 * alternating between the two buffers
 */
`default_nettype none

module feeder_write_ctl #(
   parameter int NUM_FEEDERS   = 2,
   parameter int WORDS_PER_BUF = 8
) (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       wr_accept,
   input  wire feeder_pkg::wr_word_t wr_data,
   output feeder_pkg::wr_cmd_t       wr_cmd,
   output logic                      wr_done
);

   localparam int WORD_CNT_W = feeder_pkg::cnt_width(WORDS_PER_BUF);
   // Word offset of buffer 1
   localparam feeder_pkg::word_addr_t BUF_OFFSET = feeder_pkg::word_addr_t'(WORDS_PER_BUF);

   logic [WORD_CNT_W-1:0]   word_cnt;
   feeder_pkg::feeder_sel_t feeder_cnt;
   logic                    wr_buf;
   logic                    last_word;
   logic                    last_feeder;

   // ---------------------------------------------------------------------
   // Wrap conditions
   // ---------------------------------------------------------------------
   assign last_word   = (word_cnt == WORD_CNT_W'(WORDS_PER_BUF - 1));
   assign last_feeder = (feeder_cnt == feeder_pkg::feeder_sel_t'(NUM_FEEDERS - 1));

   // Last word of the last feeder fills the buffer
   assign wr_done = wr_accept && last_word && last_feeder;

   // Command straight from the counters, registered in slice 0
   always_comb begin
      wr_cmd.valid = wr_accept;
      wr_cmd.sel   = feeder_cnt;
      wr_cmd.addr  = (wr_buf ? BUF_OFFSET : '0) + feeder_pkg::word_addr_t'(word_cnt);
      wr_cmd.data  = wr_data;
   end

   // ---------------------------------------------------------------------
   // Counters: word, then feeder, then buffer
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         word_cnt   <= '0;
         feeder_cnt <= '0;
         wr_buf     <= 1'b0;
      end else if (wr_accept) begin
         if (last_word) begin
            word_cnt <= '0;
            if (last_feeder) begin
               feeder_cnt <= '0;
               wr_buf     <= ~wr_buf;
            end else begin
               feeder_cnt <= feeder_cnt + 1'b1;
            end
         end else begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb/tb_feeder_bank.sv
/*
 * Feeder bank testbench
 * Random writes and reads against a model of the write distribution,
 * the read order, the buffer count and the chain latency
 */
`default_nettype none

module tb_feeder_bank;

   localparam int NUM_FEEDERS      = 2;
   localparam int LEAD_INTERLEAVE  = 4;
   localparam int REUSE_COUNT      = 2;
   localparam int INTERLEAVE_DEPTH = 4;
   localparam int VECS_PER_BUF     = LEAD_INTERLEAVE * INTERLEAVE_DEPTH;
   localparam int WORDS_PER_BUF    = VECS_PER_BUF / 2;
   localparam int VW               = feeder_pkg::VECTOR_WIDTH;
   localparam int MIN_PASSES       = 6;

   // One expected vector per feeder for a single read step
   typedef feeder_pkg::vec_t [NUM_FEEDERS-1:0] vec_row_t;

   logic                                 clk;
   logic                                 rst;
   logic                                 wr_valid;
   feeder_pkg::wr_word_t                 wr_data;
   logic                                 wr_ready;
   logic                                 rd_valid;
   logic                                 rd_ready;
   feeder_pkg::vec_t [NUM_FEEDERS-1:0]   rd_data;
   logic [NUM_FEEDERS-1:0]               rd_data_valid;

   int    seed = 86;
   string phase = "reset";
   int    cycle;
   int    data_errors;
   int    flag_errors;
   int    timeouts;
   int    vec_checks;
   int    passes_done;

   // Model state
   feeder_pkg::vec_t model_mem [NUM_FEEDERS][2*VECS_PER_BUF];
   int       m_word, m_feeder, m_wbuf;
   int       m_col, m_reuse, m_depth, m_rbuf;
   int       fill;
   logic     exp_wr_ready;
   logic     exp_rd_ready;
   int       acc_q [$];
   vec_row_t exp_q [$];

   feeder_bank #(
      .NUM_FEEDERS      (NUM_FEEDERS),
      .LEAD_INTERLEAVE  (LEAD_INTERLEAVE),
      .REUSE_COUNT      (REUSE_COUNT),
      .INTERLEAVE_DEPTH (INTERLEAVE_DEPTH)
   ) u_dut (
      .clk           (clk),
      .rst           (rst),
      .wr_valid      (wr_valid),
      .wr_data       (wr_data),
      .wr_ready      (wr_ready),
      .rd_valid      (rd_valid),
      .rd_ready      (rd_ready),
      .rd_data       (rd_data),
      .rd_data_valid (rd_data_valid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // Compare tasks
   // ----------------------------------------------------------------------
   task automatic check_vec(input string name, input feeder_pkg::vec_t exp,
                            input feeder_pkg::vec_t act);
      if (act !== exp) begin
         data_errors++;
         $display("** Error [%s] %s at cycle %0d: expected %h, actual %h",
                  phase, name, cycle, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         flag_errors++;
         $display("** Error [%s] %s at cycle %0d: expected %b, actual %b",
                  phase, name, cycle, exp, act);
      end
   endtask

   // Percent chance from the seeded generator
   function automatic bit chance(input int pct);
      return ((($random(seed)) & 32'h7fffffff) % 100) < pct;
   endfunction

   // ----------------------------------------------------------------------
   // Model: write distribution and read order
   // ----------------------------------------------------------------------
   task automatic model_write(input feeder_pkg::wr_word_t data, output bit done);
      int base;
      base = m_wbuf * WORDS_PER_BUF + m_word;
      // Even vector in the low half
      model_mem[m_feeder][2*base]   = data[VW-1:0];
      model_mem[m_feeder][2*base+1] = data[2*VW-1:VW];
      done = 1'b0;
      if (m_word == WORDS_PER_BUF - 1) begin
         m_word = 0;
         if (m_feeder == NUM_FEEDERS - 1) begin
            m_feeder = 0;
            m_wbuf   = 1 - m_wbuf;
            done     = 1'b1;
         end else begin
            m_feeder++;
         end
      end else begin
         m_word++;
      end
   endtask

   task automatic model_read(output bit done);
      int       addr;
      vec_row_t row;
      addr = m_rbuf * VECS_PER_BUF + m_depth * LEAD_INTERLEAVE + m_col;
      for (int i = 0; i < NUM_FEEDERS; i++) begin
         row[i] = model_mem[i][addr];
      end
      acc_q.push_back(cycle);
      exp_q.push_back(row);
      done = 1'b0;
      if (m_col == LEAD_INTERLEAVE - 1) begin
         m_col = 0;
         if (m_reuse == REUSE_COUNT - 1) begin
            m_reuse = 0;
            if (m_depth == INTERLEAVE_DEPTH - 1) begin
               m_depth = 0;
               m_rbuf  = 1 - m_rbuf;
               done    = 1'b1;
            end else begin
               m_depth++;
            end
         end else begin
            m_reuse++;
         end
      end else begin
         m_col++;
      end
   endtask

   // ----------------------------------------------------------------------
   // Monitor, samples on the falling edge where everything is settled
   // ----------------------------------------------------------------------
   always @(negedge clk) begin
      bit               wr_fin;
      bit               rd_fin;
      bit               found;
      feeder_pkg::vec_t exp_v;
      wr_fin = 1'b0;
      rd_fin = 1'b0;
      if (rst) begin
         cycle        = 0;
         fill         = 0;
         m_word       = 0;
         m_feeder     = 0;
         m_wbuf       = 0;
         m_col        = 0;
         m_reuse      = 0;
         m_depth      = 0;
         m_rbuf       = 0;
         exp_wr_ready = 1'b0;
         exp_rd_ready = 1'b0;
         acc_q.delete();
         exp_q.delete();
      end else begin
         cycle++;
         check_bit("wr_ready", exp_wr_ready, wr_ready);
         check_bit("rd_ready", exp_rd_ready, rd_ready);
         // Read accepted in cycle T is due on feeder i in cycle T+4+i
         for (int i = 0; i < NUM_FEEDERS; i++) begin
            found = 1'b0;
            exp_v = '0;
            foreach (acc_q[k]) begin
               if (acc_q[k] + 4 + i == cycle) begin
                  found = 1'b1;
                  exp_v = exp_q[k][i];
               end
            end
            if (found) vec_checks++;
            check_bit($sformatf("rd_data_valid[%0d]", i), found, rd_data_valid[i]);
            check_vec($sformatf("rd_data[%0d]", i), exp_v, rd_data[i]);
         end
         // Retire steps seen by the last feeder
         while (acc_q.size() > 0 && acc_q[0] + 3 + NUM_FEEDERS <= cycle) begin
            void'(acc_q.pop_front());
            void'(exp_q.pop_front());
         end
         // Writes first, a read never targets the buffer being written
         if (wr_valid && wr_ready) model_write(wr_data, wr_fin);
         if (rd_valid && rd_ready) model_read(rd_fin);
         if (rd_fin) passes_done++;
         if (wr_fin && !rd_fin) fill++;
         if (rd_fin && !wr_fin) fill--;
         exp_wr_ready = (fill < 2);
         exp_rd_ready = (fill > 0);
      end
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   task automatic drive_random();
      @(posedge clk);
      wr_valid <= chance(70);
      wr_data  <= {$random(seed), $random(seed)};
      rd_valid <= chance(60);
   endtask

   task automatic run_random_until(input int target, input int limit);
      int n;
      n = 0;
      while (passes_done < target && n < limit) begin
         drive_random();
         n++;
      end
      if (passes_done < target) begin
         timeouts++;
         $display("Timeout: only %0d of %0d buffer passes read", passes_done, target);
      end
   endtask

   // Holds the current valids, refreshes only the write data
   task automatic wait_fill(input int target, input int limit);
      int n;
      n = 0;
      while (fill != target && n < limit) begin
         @(posedge clk);
         wr_data <= {$random(seed), $random(seed)};
         n++;
      end
      if (fill != target) begin
         timeouts++;
         $display("Timeout: buffer count stuck at %0d, waiting for %0d", fill, target);
      end
   endtask

   task automatic wait_quiet(input int limit);
      int n;
      n = 0;
      while (acc_q.size() > 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (acc_q.size() > 0) begin
         timeouts++;
         $display("Timeout: %0d read steps never produced output", acc_q.size());
      end
   endtask

   task automatic finish_run();
      $display("Errors: data %0d, flags %0d, timeouts %0d; vectors %0d, passes %0d",
               data_errors, flag_errors, timeouts, vec_checks, passes_done);
      if (passes_done < MIN_PASSES) begin
         $display("Too few buffer passes were read");
      end
      if (data_errors == 0 && flag_errors == 0 && timeouts == 0 &&
          passes_done >= MIN_PASSES) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   endtask

   initial begin
      rst         = 1'b1;
      wr_valid    = 1'b0;
      wr_data     = '0;
      rd_valid    = 1'b0;
      data_errors = 0;
      flag_errors = 0;
      timeouts    = 0;
      vec_checks  = 0;
      passes_done = 0;
      repeat (10) @(posedge clk);
      rst <= 1'b0;

      phase = "random";
      run_random_until(3, 2000);
      // Reads held off until both buffers are full
      if (timeouts == 0) begin
         phase = "stall";
         @(posedge clk);
         wr_valid <= 1'b1;
         rd_valid <= 1'b0;
         wait_fill(2, 500);
         repeat (40) @(posedge clk);
      end
      // Drain with rd_valid held, then keep it high while rd_ready is low
      if (timeouts == 0) begin
         phase = "drain";
         wr_valid <= 1'b0;
         rd_valid <= 1'b1;
         wait_fill(0, 500);
         repeat (12) @(posedge clk);
      end
      if (timeouts == 0) begin
         phase = "random2";
         run_random_until(passes_done + 3, 3000);
      end
      phase = "quiet";
      @(posedge clk);
      wr_valid <= 1'b0;
      rd_valid <= 1'b0;
      wait_quiet(100);
      repeat (8) @(posedge clk);
      finish_run();
   end

endmodule

`default_nettype wire
